// ==== source/car_pkg.sv ====
// Shared bus types and address map for the carfield_lite subsystem
// Each window spans WindowSize bytes, and addresses outside all windows decode to TGT_NONE
// Pad registers are selected by word address bits [3:2] inside the pad window
package car_pkg;

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;

  // One access, 49 bits
  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  // One response, 33 bits
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    TGT_L2_INTL,
    TGT_L2_FLAT,
    TGT_PADS,
    TGT_NONE
  } target_e;

  // Window bases, both L2 windows alias the same storage
  localparam logic [AddrWidth-1:0] L2IntlBase = 'h0000;
  localparam logic [AddrWidth-1:0] L2FlatBase = 'h1000;
  localparam logic [AddrWidth-1:0] PadBase    = 'h2000;
  localparam logic [AddrWidth-1:0] WindowSize = 'h0100;

  typedef enum logic [1:0] {
    PAD_OUT  = 2'd0,
    PAD_OE   = 2'd1,
    PAD_IN   = 2'd2,
    PAD_RSVD = 2'd3
  } pad_reg_e;

endpackage

// ==== source/car_xbar.sv ====
// Single-master system bus: decodes each access to one target, no back-pressure
// Targets answer one cycle after their valid, the response mux is lined up with that
// Unmapped addresses get err set and zero read data, without touching any target
module car_xbar import car_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  input  bus_req_t req_i,
  output logic     l2_valid_o,
  output bus_req_t l2_req_o,
  output logic     l2_intl_o,
  input  bus_rsp_t l2_rsp_i,
  output logic     pad_valid_o,
  output bus_req_t pad_req_o,
  input  bus_rsp_t pad_rsp_i,
  output logic     rsp_valid_o,
  output bus_rsp_t rsp_o
);

  target_e  tgt;
  target_e  tgt_q;
  logic     valid_q;
  bus_req_t fwd_req;

  logic [AddrWidth-1:0] intl_off;
  logic [AddrWidth-1:0] flat_off;
  logic [AddrWidth-1:0] pad_off;

  // Offsets wrap to large values when the address lies below the base
  assign intl_off = req_i.addr - L2IntlBase;
  assign flat_off = req_i.addr - L2FlatBase;
  assign pad_off  = req_i.addr - PadBase;

  always_comb begin
    fwd_req = req_i;
    tgt     = TGT_NONE;
    if (intl_off < WindowSize) begin
      tgt          = TGT_L2_INTL;
      fwd_req.addr = intl_off;
    end else if (flat_off < WindowSize) begin
      tgt          = TGT_L2_FLAT;
      fwd_req.addr = flat_off;
    end else if (pad_off < WindowSize) begin
      tgt          = TGT_PADS;
      fwd_req.addr = pad_off;
    end
  end

  assign l2_valid_o  = req_valid_i && (tgt == TGT_L2_INTL || tgt == TGT_L2_FLAT);
  assign l2_intl_o   = (tgt == TGT_L2_INTL);
  assign l2_req_o    = fwd_req;
  assign pad_valid_o = req_valid_i && (tgt == TGT_PADS);
  assign pad_req_o   = fwd_req;

  // Remember who was addressed, matches target latency
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      tgt_q   <= TGT_NONE;
    end else begin
      valid_q <= req_valid_i;
      tgt_q   <= tgt;
    end
  end

  assign rsp_valid_o = valid_q;

  always_comb begin
    case (tgt_q)
      TGT_L2_INTL, TGT_L2_FLAT: rsp_o = l2_rsp_i;
      TGT_PADS:                 rsp_o = pad_rsp_i;
      default:                  rsp_o = '{rdata: '0, err: 1'b1};
    endcase
  end

endmodule

// ==== source/car_l2_mem.sv ====
// Two-bank L2 memory reached through an interleaved and a flat window
// L2Words must be even and at most WindowSize/4, contents are undefined after reset
// Reads and writes take effect one cycle after valid_i, err is always 0
module car_l2_mem import car_pkg::*; #(
  parameter int unsigned L2Words = 64
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  bus_req_t req_i,
  input  logic     intl_i,
  output bus_rsp_t rsp_o
);

  localparam int unsigned Half = L2Words / 2;
  localparam int unsigned RowW = (Half > 1) ? $clog2(Half) : 1;

  logic [DataWidth-1:0] mem_q [2][Half];
  logic [DataWidth-1:0] rdata_q;

  logic [AddrWidth-3:0] word;
  logic                 bank;
  logic [RowW-1:0]      row;

  // Window offset in words
  assign word = req_i.addr[AddrWidth-1:2];

  always_comb begin
    if (intl_i) begin
      // Neighbouring words alternate between banks
      bank = word[0];
      row  = RowW'((word >> 1) % Half);
    end else begin
      // Lower half in bank 0, upper half in bank 1
      bank = 1'(word / Half);
      row  = RowW'(word % Half);
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && req_i.we) begin
      mem_q[bank][row] <= req_i.wdata;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (valid_i) begin
      rdata_q <= req_i.we ? '0 : mem_q[bank][row];
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: 1'b0};

endmodule

// ==== source/car_pad_regs.sv ====
// Pad control block with output values, output enables and sampled inputs
// pad_oe_no is active low, so every pad is disabled after reset
// NumPads is at most 32, reads are zero-extended to the bus width
module car_pad_regs import car_pkg::*; #(
  parameter int unsigned NumPads = 8
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  bus_req_t           req_i,
  input  logic [NumPads-1:0] pad_i,
  output logic [NumPads-1:0] pad_o,
  output logic [NumPads-1:0] pad_oe_no,
  output bus_rsp_t           rsp_o
);

  logic [NumPads-1:0]   out_q;
  logic [NumPads-1:0]   oe_q;
  logic [DataWidth-1:0] rdata_d;
  logic [DataWidth-1:0] rdata_q;
  logic                 err_q;
  pad_reg_e             reg_sel;

  assign reg_sel = pad_reg_e'(req_i.addr[3:2]);

  // pad_i is taken in the request cycle
  always_comb begin
    case (reg_sel)
      PAD_OUT: rdata_d = DataWidth'(out_q);
      PAD_OE:  rdata_d = DataWidth'(oe_q);
      PAD_IN:  rdata_d = DataWidth'(pad_i);
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else if (valid_i) begin
      err_q   <= (reg_sel == PAD_RSVD);
      rdata_q <= req_i.we ? '0 : rdata_d;
      if (req_i.we) begin
        case (reg_sel)
          PAD_OUT: out_q <= req_i.wdata[NumPads-1:0];
          PAD_OE:  oe_q  <= req_i.wdata[NumPads-1:0];
          // Input register is read-only, reserved slot flags err
          default: ;
        endcase
      end
    end
  end

  assign pad_o     = out_q;
  // Enable flipped to pad polarity
  assign pad_oe_no = ~oe_q;

  assign rsp_o = '{rdata: rdata_q, err: err_q};

endmodule

// ==== source/carfield_lite.sv ====
// Memory and pad subsystem top level, single clock, one access per cycle
// Every request gets rsp_valid_o exactly one cycle later, writes included
// Parameters are passed down to the L2 and the pad block
module carfield_lite import car_pkg::*; #(
  parameter int unsigned L2Words = 64,
  parameter int unsigned NumPads = 8
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  input  bus_req_t           req_i,
  output logic               rsp_valid_o,
  output bus_rsp_t           rsp_o,
  input  logic [NumPads-1:0] pad_i,
  output logic [NumPads-1:0] pad_o,
  output logic [NumPads-1:0] pad_oe_no
);

  logic     l2_valid;
  logic     l2_intl;
  bus_req_t l2_req;
  bus_rsp_t l2_rsp;

  logic     pad_valid;
  bus_req_t pad_req;
  bus_rsp_t pad_rsp;

  car_xbar i_xbar (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .l2_valid_o  ( l2_valid    ),
    .l2_req_o    ( l2_req      ),
    .l2_intl_o   ( l2_intl     ),
    .l2_rsp_i    ( l2_rsp      ),
    .pad_valid_o ( pad_valid   ),
    .pad_req_o   ( pad_req     ),
    .pad_rsp_i   ( pad_rsp     ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       )
  );

  car_l2_mem #(
    .L2Words ( L2Words )
  ) i_l2_mem (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .valid_i ( l2_valid ),
    .req_i   ( l2_req   ),
    .intl_i  ( l2_intl  ),
    .rsp_o   ( l2_rsp   )
  );

  car_pad_regs #(
    .NumPads ( NumPads )
  ) i_pad_regs (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .valid_i   ( pad_valid ),
    .req_i     ( pad_req   ),
    .pad_i     ( pad_i     ),
    .pad_o     ( pad_o     ),
    .pad_oe_no ( pad_oe_no ),
    .rsp_o     ( pad_rsp   )
  );

endmodule

// ==== dv/tb_carfield_lite.sv ====
// Self-checking testbench that replays dv/stimulus_carfield_lite.txt
// Run from the project root so that the stimulus path resolves
// Expected values in the stimulus file assume the default parameters of 64 L2 words and 8 pads
module tb_carfield_lite import car_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod = 40;
  localparam int NumPads   = 8;

  // One access from the stimulus file with its expected results
  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [NumPads-1:0]   pad_in;
    logic [DataWidth-1:0] exp_rdata;
    logic                 exp_err;
    logic [NumPads-1:0]   exp_pad_o;
    logic [NumPads-1:0]   exp_oe_no;
    logic                 gap_before;
    logic [7:0]           test_idx;
  } vec_t;

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  bus_req_t           req;
  logic               rsp_valid;
  bus_rsp_t           rsp;
  logic [NumPads-1:0] pad_in;
  logic [NumPads-1:0] pad_out;
  logic [NumPads-1:0] pad_oe_n;

  vec_t        vecs[$];
  string       test_names[$];
  logic [15:0] lfsr_state;
  bit          loaded;
  int          fail_count;
  int          check_count;
  int          access_count;
  int          test_accesses;
  int          test_fails;

  carfield_lite UUT (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .req_valid_i ( req_valid ),
    .req_i       ( req       ),
    .rsp_valid_o ( rsp_valid ),
    .rsp_o       ( rsp       ),
    .pad_i       ( pad_in    ),
    .pad_o       ( pad_out   ),
    .pad_oe_no   ( pad_oe_n  )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  // Two fresh bits give 0 to 3 idle cycles
  function automatic int draw_gap();
    logic b0;
    logic b1;
    lfsr_state = lfsr_step(lfsr_state);
    b0 = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
    b1 = lfsr_state[0];
    return {b1, b0};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      $display("FAILED at %0d ns: %s expected %h actual %h", $time, name, expected, actual);
      fail_count++;
      test_fails++;
    end
  endtask

  task automatic load_stimulus(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_pad;
    logic [31:0] f_rdata;
    logic [31:0] f_err;
    logic [31:0] f_pad_o;
    logic [31:0] f_oe_no;
    bit          pending_gap;
    vec_t        v;
    ok = 1'b0;
    pending_gap = 1'b1;
    fd = $fopen("dv/stimulus_carfield_lite.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open dv/stimulus_carfield_lite.txt");
    end else begin
      ok = 1'b1;
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 3) begin
          pending_gap = 1'b1;
        end else if (line.substr(0, 1) == "//") begin
          // Comment lines leave the current group open
        end else if (line.substr(0, 4) == "test ") begin
          test_names.push_back(line.substr(5, line.len() - 2));
          pending_gap = 1'b1;
        end else begin
          n = $sscanf(line, "%c %h %h %h %h %h %h %h", op, f_addr, f_wdata, f_pad,
                      f_rdata, f_err, f_pad_o, f_oe_no);
          if (n != 8 || !(op == "W" || op == "R") || test_names.size() == 0) begin
            $display("ERROR: malformed stimulus line: %s", line);
            ok = 1'b0;
          end else begin
            v.we         = (op == "W");
            v.addr       = f_addr[AddrWidth-1:0];
            v.wdata      = f_wdata;
            v.pad_in     = f_pad[NumPads-1:0];
            v.exp_rdata  = f_rdata;
            v.exp_err    = f_err[0];
            v.exp_pad_o  = f_pad_o[NumPads-1:0];
            v.exp_oe_no  = f_oe_no[NumPads-1:0];
            v.gap_before = pending_gap;
            v.test_idx   = 8'(test_names.size() - 1);
            vecs.push_back(v);
            pending_gap = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s done: %0d accesses, %0d failures", name, test_accesses, test_fails);
  endtask

  // rsp_valid_o must stay low when nothing was requested
  task automatic idle_cycles(input int n);
    req_valid = 1'b0;
    req       = '0;
    repeat (n) begin
      @(posedge clk);
      #1;
      if (rsp_valid !== 1'b0) begin
        $display("ERROR at %0d ns: response seen without a request", $time);
        fail_count++;
        test_fails++;
      end
      #1;
    end
  endtask

  task automatic run_access(input vec_t v);
    string kind;
    kind = v.we ? "write" : "read";
    req_valid = 1'b1;
    req.we    = v.we;
    req.addr  = v.addr;
    req.wdata = v.wdata;
    pad_in    = v.pad_in;
    @(posedge clk);
    #1;
    access_count++;
    test_accesses++;
    if (rsp_valid !== 1'b1) begin
      $display("ERROR at %0d ns: no response in the cycle after the %s to %h",
               $time, kind, v.addr);
      fail_count++;
      test_fails++;
    end else begin
      check_value("rsp_o.rdata", v.exp_rdata, rsp.rdata);
      check_value("rsp_o.err", v.exp_err, rsp.err);
    end
    check_value("pad_o", v.exp_pad_o, pad_out);
    check_value("pad_oe_no", v.exp_oe_no, pad_oe_n);
    #1;
  endtask

  task automatic reset_and_check();
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    test_accesses = 0;
    test_fails    = 0;
    check_value("rsp_valid_o", 1'b0, rsp_valid);
    check_value("pad_oe_no", {NumPads{1'b1}}, pad_oe_n);
    check_value("pad_o", '0, pad_out);
    report_test("reset_state");
    #1;
  endtask

  task automatic run_all();
    int cur;
    cur = -1;
    foreach (vecs[i]) begin
      if (int'(vecs[i].test_idx) != cur) begin
        if (cur >= 0) report_test(test_names[cur]);
        cur           = vecs[i].test_idx;
        test_accesses = 0;
        test_fails    = 0;
      end
      if (vecs[i].gap_before) idle_cycles(draw_gap());
      run_access(vecs[i]);
    end
    if (cur >= 0) report_test(test_names[cur]);
    idle_cycles(1);
  endtask

  initial begin
    bit ok;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    pad_in     = '0;
    lfsr_state = 16'd11700;
    load_stimulus(ok);
    loaded = 1'b1;
    if (!ok) begin
      $display(">>> FAIL");
      $finish;
    end else begin
      reset_and_check();
      run_all();
      $display("summary: %0d tests, %0d accesses, %0d checks, %0d failures",
               test_names.size() + 1, access_count, check_count, fail_count);
      if (fail_count == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

  // Budget of five cycles per access plus reset
  initial begin
    int limit;
    wait (loaded);
    limit = vecs.size() * 5 + 20;
    #(limit * ClkPeriod);
    $display("ERROR: timeout after %0d clock periods, the run did not finish", limit);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== carfield_lite.f ====
source/car_pkg.sv
source/car_xbar.sv
source/car_l2_mem.sv
source/car_pad_regs.sv
source/carfield_lite.sv
dv/tb_carfield_lite.sv

// ==== Bender.yml ====
package:
  name: carfield_lite

sources:
  - source/car_pkg.sv
  - source/car_xbar.sv
  - source/car_l2_mem.sv
  - source/car_pad_regs.sv
  - source/carfield_lite.sv
  - target: simulation
    files:
      - dv/tb_carfield_lite.sv

// ==== dv/stimulus_carfield_lite.txt ====
// op addr wdata pad_i | expected rdata err pad_o pad_oe_no, all hex
// A test line names the next test, a blank line ends a group of back-to-back accesses
test intl_write_flat_read
W 0000 11110000 00 00000000 0 00 ff
W 0004 22220001 00 00000000 0 00 ff
W 0014 33330005 00 00000000 0 00 ff
W 0028 4444000a 00 00000000 0 00 ff
R 1000 00000000 00 11110000 0 00 ff
R 1080 00000000 00 22220001 0 00 ff
R 1088 00000000 00 33330005 0 00 ff
R 1014 00000000 00 4444000a 0 00 ff

W 101c 55550007 00 00000000 0 00 ff
W 10a0 66660028 00 00000000 0 00 ff
W 10fc 7777003f 00 00000000 0 00 ff
R 0038 00000000 00 55550007 0 00 ff
R 0044 00000000 00 66660028 0 00 ff
R 00fc 00000000 00 7777003f 0 00 ff

test back_to_back
W 0020 a5a50008 00 00000000 0 00 ff
R 0020 00000000 00 a5a50008 0 00 ff
W 1090 5a5a0024 00 00000000 0 00 ff
R 0024 00000000 00 5a5a0024 0 00 ff
W 0030 c0de000c 00 00000000 0 00 ff
R 1018 00000000 00 c0de000c 0 00 ff
W 0030 0badf00d 00 00000000 0 00 ff
R 0030 00000000 00 0badf00d 0 00 ff

test pad_control
W 2000 000000a5 00 00000000 0 a5 ff
W 2004 0000000f 00 00000000 0 a5 f0
R 2000 00000000 00 000000a5 0 a5 f0
R 2004 00000000 00 0000000f 0 a5 f0
R 2008 00000000 3c 0000003c 0 a5 f0
W 2008 000000ff 3c 00000000 0 a5 f0
R 2008 00000000 3c 0000003c 0 a5 f0
R 2008 00000000 c3 000000c3 0 a5 f0

W 2000 0000005a 00 00000000 0 5a f0
W 2004 ffffff81 00 00000000 0 5a 7e
R 2004 00000000 00 00000081 0 5a 7e
R 2000 00000000 00 0000005a 0 5a 7e

test error_response
W 200c ffffffff 00 00000000 1 5a 7e
R 200c 00000000 00 00000000 1 5a 7e
W 3000 deadbeef 00 00000000 1 5a 7e
R 3000 00000000 00 00000000 1 5a 7e
W 0100 deadbeef 00 00000000 1 5a 7e
W 1100 deadbeef 00 00000000 1 5a 7e
R fffc 00000000 00 00000000 1 5a 7e
R 0000 00000000 00 11110000 0 5a 7e
R 1000 00000000 00 11110000 0 5a 7e
R 2000 00000000 00 0000005a 0 5a 7e
R 2004 00000000 00 00000081 0 5a 7e
